// File: src/la_pkg.sv
package la_pkg;

   localparam int CHN_NUM   = 8;
   localparam int RAM_DEPTH = 256;   // samples per capture
   localparam int APB_AW    = 12;

   typedef logic [CHN_NUM-1:0]           sample_t;    // one sample of all channels
   typedef logic [$clog2(RAM_DEPTH)-1:0] ram_addr_t;
   typedef logic [$clog2(CHN_NUM)-1:0]   chn_idx_t;   // monitored channel
   typedef logic [15:0]                  div_t;       // strobe every div+1 clocks

   // register map, byte addresses
   localparam logic [APB_AW-1:0] REG_CTRL   = 12'h000;
   localparam logic [APB_AW-1:0] REG_DIV    = 12'h004;
   localparam logic [APB_AW-1:0] REG_CMD    = 12'h008;
   localparam logic [APB_AW-1:0] REG_STATUS = 12'h00C;
   localparam logic [APB_AW-1:0] RAM_BASE   = 12'h400;   // window up to 0x7FC

   // 5 to 7 act as immediate trigger
   typedef enum logic [2:0] {
      TRIG_LOW      = 3'd0,
      TRIG_HIGH     = 3'd1,
      TRIG_POS      = 3'd2,
      TRIG_NEG      = 3'd3,
      TRIG_ANY_EDGE = 3'd4
   } trig_mode_e;

   typedef enum logic [1:0] {
      CAP_IDLE    = 2'd0,
      CAP_ARMED   = 2'd1,
      CAP_CAPTURE = 2'd2,
      CAP_DONE    = 2'd3
   } cap_state_e;

   typedef struct packed {
      trig_mode_e mode;
      chn_idx_t   chn;
   } trig_cfg_t;

   typedef struct packed {
      cap_state_e state;
      ram_addr_t  count;   // current write address
   } cap_status_t;

   typedef struct packed {
      logic      en;
      ram_addr_t addr;
      sample_t   data;
   } ram_wr_t;

endpackage

// File: src/sample_rate_gen.sv
module sample_rate_gen (
   input  logic         iSysClk,
   input  logic         arst_n,
   input  la_pkg::div_t div,
   output logic         sample_stb
);

   import la_pkg::*;

   div_t cnt;     // clocks left to next strobe
   div_t div_q;   // last seen divider
   logic div_chg;

   assign div_chg = (div != div_q);

   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         cnt        <= '0;
         div_q      <= '0;
         sample_stb <= 1'b0;
      end else begin
         div_q <= div;
         if (div_chg) begin
            cnt        <= div;   // restart on a new setting
            sample_stb <= 1'b0;
         end else if (cnt == '0) begin
            cnt        <= div;
            sample_stb <= 1'b1;
         end else begin
            cnt        <= cnt - 1'b1;
            sample_stb <= 1'b0;
         end
      end
   end

endmodule

// File: src/sample_ctrl.sv
module sample_ctrl (
   input  logic                iSysClk,
   input  logic                arst_n,
   input  logic                sample_stb,
   input  la_pkg::sample_t     data_in,
   input  la_pkg::trig_cfg_t   trig_cfg,
   input  logic                arm,
   input  logic                abort,
   output la_pkg::ram_wr_t     ram_wr,
   output la_pkg::cap_status_t status
);

   import la_pkg::*;

   sample_t    s_cur;
   sample_t    s_prev;
   sample_t    trig_data;
   logic       fresh;       // s_cur was loaded last cycle
   logic       trig_hit;
   logic       arm_ok;
   logic       wr_go;
   ram_addr_t  wr_addr;
   cap_state_e state;
   cap_state_e state_nxt;

   // two stage sample register, advanced on the strobe
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         s_cur  <= '0;
         s_prev <= '0;
         fresh  <= 1'b0;
      end else begin
         fresh <= sample_stb;
         if (sample_stb) begin
            s_cur  <= data_in;
            s_prev <= s_cur;
         end
      end
   end

   always_comb begin
      case (trig_cfg.mode)
         TRIG_LOW:      trig_data = ~s_cur;
         TRIG_HIGH:     trig_data = s_cur;
         TRIG_POS:      trig_data = s_cur & ~s_prev;
         TRIG_NEG:      trig_data = ~s_cur & s_prev;
         TRIG_ANY_EDGE: trig_data = s_cur ^ s_prev;
         default:       trig_data = '1;   // immediate
      endcase
   end

   assign trig_hit = trig_data[trig_cfg.chn];
   assign arm_ok   = arm & (state != CAP_CAPTURE);   // ignored mid capture

   // write the fresh sample once triggered
   assign wr_go = fresh & ~abort & ~arm_ok &
                  (((state == CAP_ARMED) & trig_hit) | (state == CAP_CAPTURE));

   always_comb begin
      state_nxt = state;
      if (abort) begin
         state_nxt = CAP_IDLE;
      end else if (arm_ok) begin
         state_nxt = CAP_ARMED;
      end else if (wr_go) begin
         if (state == CAP_ARMED) begin
            state_nxt = CAP_CAPTURE;
         end else if (wr_addr == '1) begin
            state_nxt = CAP_DONE;   // last word written
         end
      end
   end

   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         state <= CAP_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // write address, parks on the last word
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         wr_addr <= '0;
      end else if (arm_ok) begin
         wr_addr <= '0;
      end else if (wr_go && wr_addr != '1) begin
         wr_addr <= wr_addr + 1'b1;
      end
   end

   assign ram_wr = '{en: wr_go, addr: wr_addr, data: s_cur};
   assign status = '{state: state, count: wr_addr};

   // no address consumed between arm and trigger
   a_addr_moves_on_write: assert property (
      @(posedge iSysClk) disable iff (!arst_n)
      (state == CAP_ARMED) |-> (wr_addr == '0)
   );

   // done only once the last word went out
   a_no_write_idle_done: assert property (
      @(posedge iSysClk) disable iff (!arst_n)
      (state == CAP_DONE) |-> (wr_addr == '1)
   );

endmodule

// File: src/capture_ram.sv
module capture_ram (
   input  logic              iSysClk,
   input  la_pkg::ram_wr_t   ram_wr,
   input  la_pkg::ram_addr_t rd_addr,
   output la_pkg::sample_t   rd_data
);

   import la_pkg::*;

   sample_t mem [RAM_DEPTH];   // capture buffer

   // write port from the sample controller
   always_ff @(posedge iSysClk) begin
      if (ram_wr.en) begin
         mem[ram_wr.addr] <= ram_wr.data;
      end
   end

   // registered read, old data on a same address collision
   always_ff @(posedge iSysClk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: src/la_regs.sv
module la_regs (
   input  logic                      iSysClk,
   input  logic                      arst_n,
   input  logic [la_pkg::APB_AW-1:0] paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [31:0]               pwdata,
   input  la_pkg::cap_status_t       status,
   input  la_pkg::sample_t           rd_data,
   output logic [31:0]               prdata,
   output logic                      pready,
   output logic                      pslverr,
   output la_pkg::trig_cfg_t         trig_cfg,
   output la_pkg::div_t              div,
   output logic                      arm,
   output logic                      abort,
   output la_pkg::ram_addr_t         rd_addr
);

   import la_pkg::*;

   logic        hit_ctrl;
   logic        hit_div;
   logic        hit_cmd;
   logic        hit_status;
   logic        hit_reg;
   logic        hit_ram;
   logic        ram_rd;
   logic        setup_ph;
   logic        wait_ph;
   logic        acc_done;
   logic        wr_ok;
   logic [31:0] reg_rdata;

   // address decode
   assign hit_ctrl   = (paddr == REG_CTRL);
   assign hit_div    = (paddr == REG_DIV);
   assign hit_cmd    = (paddr == REG_CMD);
   assign hit_status = (paddr == REG_STATUS);
   assign hit_reg    = hit_ctrl | hit_div | hit_cmd | hit_status;
   assign hit_ram    = (paddr[APB_AW-1:10] == RAM_BASE[APB_AW-1:10]);
   assign ram_rd     = hit_ram & ~pwrite;

   // bus phases
   assign setup_ph = psel & ~penable;
   assign wait_ph  = psel & penable & ~pready;   // only a RAM read gets here
   assign acc_done = psel & penable & pready;
   assign wr_ok    = acc_done & pwrite & ~pslverr;

   assign rd_addr = paddr[9:2];   // one sample per word

   always_comb begin
      reg_rdata = '0;
      if (hit_ctrl) begin
         reg_rdata[5:0] = trig_cfg;
      end
      if (hit_div) begin
         reg_rdata[15:0] = div;
      end
      if (hit_status) begin
         reg_rdata[1:0]  = status.state;
         reg_rdata[15:8] = status.count;
      end
   end

   // completion handshake
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
         if (setup_ph && !ram_rd) begin
            pready  <= 1'b1;
            pslverr <= ~hit_reg;   // RAM writes and holes
         end else if (wait_ph && ram_rd) begin
            pready <= 1'b1;   // RAM data is out now
         end
      end
   end

   always_ff @(posedge iSysClk) begin
      if (setup_ph) begin
         prdata <= reg_rdata;
      end else if (wait_ph) begin
         prdata <= {24'h0, rd_data};
      end
   end

   // configuration and command pulses
   always_ff @(posedge iSysClk or negedge arst_n) begin
      if (!arst_n) begin
         trig_cfg <= '{mode: TRIG_HIGH, chn: '0};
         div      <= '0;
         arm      <= 1'b0;
         abort    <= 1'b0;
      end else begin
         arm   <= wr_ok & hit_cmd & pwdata[0];
         abort <= wr_ok & hit_cmd & pwdata[1];
         if (wr_ok && hit_ctrl) begin
            trig_cfg.mode <= trig_mode_e'(pwdata[5:3]);
            trig_cfg.chn  <= pwdata[2:0];
         end
         if (wr_ok && hit_div) begin
            div <= pwdata[15:0];
         end
      end
   end

   // ready only ever answers a master already in its access phase
   a_pready_in_access: assert property (
      @(posedge iSysClk) disable iff (!arst_n)
      pready |-> (psel && penable)
   );

endmodule

// File: src/logic_analyzer_top.sv
module logic_analyzer_top (
   input  logic                      iSysClk,
   input  logic                      arst_n,
   input  logic [la_pkg::APB_AW-1:0] paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [31:0]               pwdata,
   output logic [31:0]               prdata,
   output logic                      pready,
   output logic                      pslverr,
   input  la_pkg::sample_t           data_in
);

   import la_pkg::*;

   trig_cfg_t   trig_cfg;
   div_t        div;
   logic        arm;
   logic        abort;
   logic        sample_stb;
   ram_wr_t     ram_wr;
   cap_status_t status;
   ram_addr_t   rd_addr;
   sample_t     rd_data;

   la_regs regs_i (
      .iSysClk  (iSysClk),
      .arst_n   (arst_n),
      .paddr    (paddr),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .pwdata   (pwdata),
      .status   (status),
      .rd_data  (rd_data),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .trig_cfg (trig_cfg),
      .div      (div),
      .arm      (arm),
      .abort    (abort),
      .rd_addr  (rd_addr)
   );

   sample_rate_gen rate_gen_i (
      .iSysClk    (iSysClk),
      .arst_n     (arst_n),
      .div        (div),
      .sample_stb (sample_stb)
   );

   sample_ctrl ctrl_i (
      .iSysClk    (iSysClk),
      .arst_n     (arst_n),
      .sample_stb (sample_stb),
      .data_in    (data_in),
      .trig_cfg   (trig_cfg),
      .arm        (arm),
      .abort      (abort),
      .ram_wr     (ram_wr),
      .status     (status)
   );

   capture_ram ram_i (
      .iSysClk (iSysClk),
      .ram_wr  (ram_wr),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// File: verif/la_apb_bfm.svh
`ifndef LA_APB_BFM_SVH
`define LA_APB_BFM_SVH

// one APB write, setup then access until pready
task automatic apb_write(
   input  logic [la_pkg::APB_AW-1:0] addr,
   input  logic [31:0]               data,
   output logic                      err
);
   int waits;
   waits = 0;
   err   = 1'b1;
   @(posedge iSysClk);
   #DRV_DLY;
   paddr   = addr;
   pwrite  = 1'b1;
   pwdata  = data;
   psel    = 1'b1;
   penable = 1'b0;
   @(posedge iSysClk);
   #DRV_DLY;
   penable = 1'b1;
   while (!pready && waits < APB_TIMEOUT) begin
      @(posedge iSysClk);
      #DRV_DLY;
      waits++;
   end
   if (!pready) begin
      report_problem($sformatf("APB write to 0x%03h never got pready", addr));
   end else begin
      err = pslverr;
   end
   @(posedge iSysClk);   // transfer ends on this edge
   #DRV_DLY;
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

// one APB read, the RAM window adds a wait state
task automatic apb_read(
   input  logic [la_pkg::APB_AW-1:0] addr,
   output logic [31:0]               data,
   output logic                      err
);
   int waits;
   waits = 0;
   err   = 1'b1;
   data  = 'x;
   @(posedge iSysClk);
   #DRV_DLY;
   paddr   = addr;
   pwrite  = 1'b0;
   psel    = 1'b1;
   penable = 1'b0;
   @(posedge iSysClk);
   #DRV_DLY;
   penable = 1'b1;
   while (!pready && waits < APB_TIMEOUT) begin
      @(posedge iSysClk);
      #DRV_DLY;
      waits++;
   end
   if (!pready) begin
      report_problem($sformatf("APB read from 0x%03h never got pready", addr));
   end else begin
      data = prdata;   // stable until the next edge
      err  = pslverr;
   end
   @(posedge iSysClk);
   #DRV_DLY;
   psel    = 1'b0;
   penable = 1'b0;
endtask

task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
   $display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, act);
   err_cnt++;
endtask

task automatic report_problem(input string msg);
   $display("%s", msg);
   err_cnt++;
endtask

`endif

// File: verif/la_tb.sv
module la_tb;

   import la_pkg::*;

   localparam int CLK_PER     = 40;
   localparam int DRV_DLY     = 5;
   localparam int APB_TIMEOUT = 8;      // cycles in access phase
   localparam int POLL_LIMIT  = 1000;   // STATUS reads

   logic              iSysClk;
   logic              arst_n;
   logic [APB_AW-1:0] paddr;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   sample_t           data_in;
   sample_t           stim_cnt;
   logic              hold_ff;   // park channels at all ones
   integer            seed;
   int                err_cnt;
   int                pass_cnt;
   int                fail_cnt;
   int                test_err0;
   sample_t           cap_buf [RAM_DEPTH];

   `include "la_apb_bfm.svh"

   logic_analyzer_top dut_i (
      .iSysClk (iSysClk),
      .arst_n  (arst_n),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .data_in (data_in)
   );

   initial begin
      iSysClk = 1'b0;
      forever #(CLK_PER/2) iSysClk = ~iSysClk;
   end

   // counter pattern on the channels, one step per clock
   initial begin
      stim_cnt = '0;
      data_in  = '0;
      forever begin
         @(posedge iSysClk);
         #DRV_DLY;
         stim_cnt = stim_cnt + 1'b1;
         data_in  = hold_ff ? 8'hFF : stim_cnt;
      end
   end

   task automatic begin_test();
      test_err0 = err_cnt;
   endtask

   task automatic end_test(input string name);
      if (err_cnt == test_err0) begin
         pass_cnt++;
         $display("%-16s PASS", name);
      end else begin
         fail_cnt++;
         $display("%-16s FAIL (%0d errors)", name, err_cnt - test_err0);
      end
   endtask

   task automatic arm_capture(input logic [2:0] mode, input chn_idx_t chn);
      logic err;
      apb_write(REG_CTRL, {26'h0, mode, chn}, err);
      apb_write(REG_CMD, 32'h1, err);
   endtask

   task automatic wait_for_state(input cap_state_e exp);
      logic [31:0] rd;
      logic        err;
      int          polls;
      polls = 0;
      apb_read(REG_STATUS, rd, err);
      while (rd[1:0] !== exp && polls < POLL_LIMIT) begin
         apb_read(REG_STATUS, rd, err);
         polls++;
      end
      if (rd[1:0] !== exp) begin
         report_problem($sformatf("timed out waiting for capture state %0d", exp));
      end
   endtask

   task automatic read_buffer();
      logic [31:0] rd;
      logic        err;
      for (int k = 0; k < RAM_DEPTH; k++) begin
         apb_read(RAM_BASE + APB_AW'(k * 4), rd, err);
         if (err !== 1'b0) report_mismatch("pslverr", 0, err);
         cap_buf[k] = rd[7:0];
      end
   endtask

   // every word one step above the one before it
   task automatic check_step(input sample_t step);
      sample_t exp;
      for (int k = 0; k + 1 < RAM_DEPTH; k++) begin
         exp = cap_buf[k] + step;
         if (cap_buf[k+1] !== exp) begin
            report_mismatch($sformatf("ram word %0d", k + 1), exp, cap_buf[k+1]);
         end
      end
   endtask

   task automatic test_reset_regs();
      logic [31:0] rd;
      logic        err;
      begin_test();
      apb_read(REG_STATUS, rd, err);
      if (rd !== 32'h0) report_mismatch("STATUS", 32'h0, rd);
      if (err !== 1'b0) report_mismatch("pslverr", 0, err);
      apb_read(REG_CTRL, rd, err);
      if (rd !== 32'h08) report_mismatch("CTRL", 32'h08, rd);   // TRIG_HIGH, channel 0
      apb_read(REG_DIV, rd, err);
      if (rd !== 32'h0) report_mismatch("DIV", 32'h0, rd);
      apb_write(REG_CTRL, 32'h1D, err);
      apb_read(REG_CTRL, rd, err);
      if (rd !== 32'h1D) report_mismatch("CTRL", 32'h1D, rd);
      apb_write(REG_DIV, 32'h1234, err);
      apb_read(REG_DIV, rd, err);
      if (rd !== 32'h1234) report_mismatch("DIV", 32'h1234, rd);
      apb_write(RAM_BASE, 32'hAA, err);
      if (err !== 1'b1) report_mismatch("pslverr", 1, err);
      apb_read(12'h010, rd, err);   // hole in the map
      if (err !== 1'b1) report_mismatch("pslverr", 1, err);
      apb_write(12'h010, 32'h5, err);
      if (err !== 1'b1) report_mismatch("pslverr", 1, err);
      apb_write(REG_DIV, 32'h0, err);
      apb_write(REG_CTRL, 32'h08, err);
      end_test("reset_regs");
   endtask

   task automatic test_level_trigger();
      logic [31:0] rnd;
      logic        err;
      chn_idx_t    chn;
      begin_test();
      rnd = $random(seed);
      chn = rnd[2:0];
      apb_write(REG_DIV, 32'h0, err);
      arm_capture(TRIG_HIGH, chn);
      wait_for_state(CAP_DONE);
      read_buffer();
      if (cap_buf[0][chn] !== 1'b1) begin
         report_mismatch($sformatf("ram word 0 bit %0d", chn), 1, cap_buf[0][chn]);
      end
      check_step(8'd1);
      arm_capture(3'd6, chn);   // immediate
      wait_for_state(CAP_DONE);
      read_buffer();
      check_step(8'd1);
      end_test("level_trigger");
   endtask

   task automatic test_edge_triggers();
      logic [31:0] rnd;
      chn_idx_t    chn;
      sample_t     prev;
      sample_t     cur;
      logic        hit;
      begin_test();
      for (int m = 2; m <= 4; m++) begin
         rnd = $random(seed);
         chn = rnd[2:0];
         arm_capture(m[2:0], chn);
         wait_for_state(CAP_DONE);
         read_buffer();
         cur  = cap_buf[0];
         prev = cur - 1'b1;   // counter value one sample earlier
         case (m)
            2:       hit = cur[chn] & ~prev[chn];
            3:       hit = ~cur[chn] & prev[chn];
            default: hit = cur[chn] ^ prev[chn];
         endcase
         if (hit !== 1'b1) begin
            report_mismatch($sformatf("trigger bit %0d of word 0, mode %0d", chn, m), 1, hit);
         end
         check_step(8'd1);
      end
      end_test("edge_triggers");
   endtask

   task automatic test_divider();
      logic [31:0] rd;
      logic        err;
      begin_test();
      apb_write(REG_DIV, 32'h3, err);
      arm_capture(3'd5, '0);
      wait_for_state(CAP_DONE);
      apb_read(REG_STATUS, rd, err);
      if (rd[15:8] !== 8'hFF) report_mismatch("STATUS count", 8'hFF, rd[15:8]);
      read_buffer();
      check_step(8'd4);   // one sample every 4 clocks
      apb_write(REG_DIV, 32'h0, err);
      end_test("divider");
   endtask

   task automatic test_abort();
      logic [31:0] rd;
      logic        err;
      begin_test();
      hold_ff = 1'b1;
      arm_capture(TRIG_LOW, '0);
      repeat (600) @(posedge iSysClk);
      apb_read(REG_STATUS, rd, err);
      if (rd[1:0] !== CAP_ARMED) report_mismatch("STATUS state", CAP_ARMED, rd[1:0]);
      apb_write(REG_CMD, 32'h2, err);
      apb_read(REG_STATUS, rd, err);
      if (rd[1:0] !== CAP_IDLE) report_mismatch("STATUS state", CAP_IDLE, rd[1:0]);
      arm_capture(3'd7, '0);
      wait_for_state(CAP_DONE);
      apb_read(RAM_BASE, rd, err);
      if (rd !== 32'hFF) report_mismatch("ram word 0", 32'hFF, rd);
      hold_ff = 1'b0;
      end_test("abort");
   endtask

   initial begin
      seed     = 60;
      arst_n   = 1'b0;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      hold_ff  = 1'b0;
      err_cnt  = 0;
      pass_cnt = 0;
      fail_cnt = 0;
      repeat (10) @(posedge iSysClk);
      #DRV_DLY;
      arst_n = 1'b1;
      test_reset_regs();
      test_level_trigger();
      test_edge_triggers();
      test_divider();
      test_abort();
      $display("summary: %0d pass, %0d fail, %0d errors", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: files.f
+incdir+verif
src/la_pkg.sv
src/sample_rate_gen.sv
src/sample_ctrl.sv
src/capture_ram.sv
src/la_regs.sv
src/logic_analyzer_top.sv
verif/la_tb.sv
